// ==== hdl/cfg_consts.svh ====
`ifndef CFG_CONSTS_SVH
`define CFG_CONSTS_SVH

// Command ids accepted on the input stream
`define CMD_GET_REG   8'h31
`define CMD_SET_REG   8'h32

// Reply ids sent on the output stream
`define CMD_DATA_REG  8'h90
`define CMD_NOT_FOUND 8'hF0

// Command length in bytes, id byte included
`define GET_LEN 3
`define SET_LEN 4

// Table geometry
`define NUM_SLOTS 16
`define NUM_PORTS 4

`endif

// ==== hdl/cfg_pkg.sv ====
package cfg_pkg;

    // One byte of the command or reply stream
    typedef logic [7:0] byte_t;
    typedef logic [7:0] cmd_id_t;

    // Port number taken from the second command byte
    typedef logic [1:0] port_t;
    typedef logic [5:0] reg_addr_t;

    // Bank is {port, direction bit, channel bit}
    typedef logic [3:0] bank_t;
    typedef logic [3:0] slot_t;

    // Bit 6 is the used flag, bits 5:0 the register address
    typedef logic [6:0] tag_t;

    // Sequencer states
    typedef enum logic [2:0] {
        st_idle,
        st_search,
        st_wait_read,
        st_decide,
        st_write,
        st_reply,
        st_finish
    } seq_state_t;

endpackage

// ==== hdl/table_if.sv ====
`timescale 1ns/1ps

interface table_if;
    import cfg_pkg::*;

    // Entry select, bank from the sequencer and slot from the counter
    bank_t   bank;
    slot_t   slot;

    // Write port
    logic    wr_en;
    tag_t    wr_tag;
    byte_t   wr_value;

    // Read data, one cycle behind bank and slot
    tag_t    rd_tag;
    byte_t   rd_value;

    modport seq (output bank, output wr_en, output wr_tag, output wr_value,
                 input rd_tag, input rd_value);

    modport counter (output slot);

    // Storage side of the table
    modport storage (input bank, input slot, input wr_en, input wr_tag, input wr_value,
                     output rd_tag, output rd_value);

endinterface

// ==== hdl/cmd_assembler.sv ====
`timescale 1ns/1ps
`include "cfg_consts.svh"

module cmd_assembler (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  cfg_pkg::byte_t     in_byte,
    input  logic               busy,
    output logic               cmd_done,
    output cfg_pkg::cmd_id_t   cmd_id,
    output cfg_pkg::port_t     port,
    output cfg_pkg::reg_addr_t reg_addr,
    output cfg_pkg::byte_t     value
);
    // Bytes accepted so far and the length of the command in progress
    logic [2:0] byte_cnt;
    logic [2:0] cmd_len;
    logic [2:0] len_now;
    logic       accept;

    assign accept = in_valid && !busy;

    // Length comes from the id byte itself, later bytes use the stored one
    always_comb begin
        len_now = cmd_len;
        if (byte_cnt == 3'd0) begin
            case (in_byte)
                `CMD_GET_REG: len_now = 3'(`GET_LEN);
                `CMD_SET_REG: len_now = 3'(`SET_LEN);
                // Unknown ids are one byte long
                default:      len_now = 3'd1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_cnt <= 3'd0;
            cmd_len  <= 3'd0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            if (accept) begin
                cmd_len <= len_now;
                // Last byte wraps the count and flags the command
                if (byte_cnt + 3'd1 == len_now) begin
                    byte_cnt <= 3'd0;
                    cmd_done <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 3'd1;
                end
            end
        end
    end

    // Field capture by byte position
    always_ff @(posedge clk) begin
        if (accept) begin
            case (byte_cnt)
                3'd0:    cmd_id   <= in_byte;
                3'd1:    port     <= in_byte[1:0];
                3'd2:    reg_addr <= in_byte[5:0];
                default: value    <= in_byte;
            endcase
        end
    end

endmodule

// ==== hdl/slot_counter.sv ====
`timescale 1ns/1ps
`include "cfg_consts.svh"

module slot_counter (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  logic   step,
    table_if.counter tbl,
    output logic   bank_end
);
    import cfg_pkg::*;

    // Slot under examination in the current search
    slot_t slot_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slot_q <= '0;
        end else if (start) begin
            // New search starts at the first slot
            slot_q <= '0;
        end else if (step) begin
            slot_q <= slot_q + slot_t'(1);
        end
    end

    assign tbl.slot = slot_q;

    // Last slot of the bank, no further step possible
    assign bank_end = (slot_q == slot_t'(`NUM_SLOTS - 1));

endmodule

// ==== hdl/config_table.sv ====
`timescale 1ns/1ps
`include "cfg_consts.svh"

module config_table (
    input  logic    clk,
    input  logic    reset,
    table_if.storage tbl
);
    import cfg_pkg::*;

    // Four banks per port for the direction and channel combinations
    localparam int DEPTH = `NUM_PORTS * 4 * `NUM_SLOTS;

    logic [$clog2(DEPTH)-1:0] addr;

    // Used flag of every entry, all cleared by reset
    logic [DEPTH-1:0] used_q;

    // Register addresses and values
    reg_addr_t addr_mem [DEPTH];
    byte_t     val_mem  [DEPTH];

    assign addr = {tbl.bank, tbl.slot};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            used_q <= '0;
        end else if (tbl.wr_en) begin
            used_q[addr] <= tbl.wr_tag[6];
        end
    end

    always_ff @(posedge clk) begin
        if (tbl.wr_en) begin
            addr_mem[addr] <= tbl.wr_tag[5:0];
            val_mem[addr]  <= tbl.wr_value;
        end
        // Read data is registered and valid the cycle after the address
        tbl.rd_tag   <= {used_q[addr], addr_mem[addr]};
        tbl.rd_value <= val_mem[addr];
    end

endmodule

// ==== hdl/cmd_sequencer.sv ====
`timescale 1ns/1ps
`include "cfg_consts.svh"

module cmd_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_done,
    input  cfg_pkg::cmd_id_t        cmd_id,
    input  cfg_pkg::port_t          port,
    input  cfg_pkg::reg_addr_t      reg_addr,
    input  cfg_pkg::byte_t          value,
    input  logic [`NUM_PORTS-1:0]   direction,
    input  logic [`NUM_PORTS-1:0]   num_channels,
    input  logic                    serial_busy,
    output logic                    busy,
    output logic                    start,
    output logic                    step,
    input  logic                    bank_end,
    table_if.seq                    tbl,
    output logic                    send,
    output cfg_pkg::cmd_id_t        send_id,
    output logic [1:0]              send_len,
    output cfg_pkg::byte_t          send_b0,
    output cfg_pkg::byte_t          send_b1
);
    import cfg_pkg::*;

    seq_state_t state;
    seq_state_t next;
    bank_t      bank_q;
    logic       is_get;
    logic       is_set;
    logic       hit;
    logic       free;

    assign is_get = (cmd_id == `CMD_GET_REG);
    assign is_set = (cmd_id == `CMD_SET_REG);

    // Slot compare on the registered read data
    assign hit  = tbl.rd_tag[6] && (tbl.rd_tag[5:0] == reg_addr);
    assign free = !tbl.rd_tag[6];

    always_comb begin
        next  = state;
        start = 1'b0;
        step  = 1'b0;
        case (state)
            st_idle: begin
                if (cmd_done) begin
                    next = (is_get || is_set) ? st_search : st_finish;
                end
            end
            // Point the counter at slot 0
            st_search: begin
                start = 1'b1;
                next  = st_wait_read;
            end
            st_wait_read: next = st_decide;
            st_decide: begin
                if (is_get && (hit || free || bank_end)) begin
                    next = st_reply;
                end else if (is_set && (hit || free)) begin
                    next = st_write;
                end else if (bank_end) begin
                    // Bank full on a set
                    next = st_reply;
                end else begin
                    step = 1'b1;
                    next = st_wait_read;
                end
            end
            st_write:  next = st_idle;
            st_reply:  next = st_finish;
            // Hold until the last reply byte is on the output
            st_finish: begin
                if (!serial_busy) begin
                    next = st_idle;
                end
            end
            default:   next = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next;
        end
    end

    // Bank select and reply contents
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_done) begin
            bank_q <= {port, direction[port], num_channels[port]};
        end
        if (state == st_decide) begin
            if (is_get && hit) begin
                send_id  <= `CMD_DATA_REG;
                send_len <= 2'd2;
            end else begin
                send_id  <= `CMD_NOT_FOUND;
                send_len <= 2'd0;
            end
            send_b0 <= byte_t'(reg_addr);
            send_b1 <= tbl.rd_value;
        end
    end

    assign send = (state == st_reply);

    // Matched or free slot gets the tag and value
    assign tbl.bank     = bank_q;
    assign tbl.wr_en    = (state == st_write);
    assign tbl.wr_tag   = {1'b1, reg_addr};
    assign tbl.wr_value = value;

    assign busy = cmd_done || (state != st_idle);

endmodule

// ==== hdl/reply_serializer.sv ====
`timescale 1ns/1ps

module reply_serializer (
    input  logic             clk,
    input  logic             reset,
    input  logic             send,
    input  cfg_pkg::cmd_id_t send_id,
    input  logic [1:0]       send_len,
    input  cfg_pkg::byte_t   send_b0,
    input  cfg_pkg::byte_t   send_b1,
    output logic             out_valid,
    output cfg_pkg::byte_t   out_byte,
    output logic             out_last,
    output logic             serial_busy
);
    import cfg_pkg::*;

    // Payload bytes sent so far and the reply held for sending
    logic [1:0] idx;
    logic [1:0] len_q;
    byte_t      b0_q;
    byte_t      b1_q;
    logic       more;

    assign more = out_valid && !out_last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            idx       <= 2'd0;
        end else if (send) begin
            // Id byte first, last already if there is no payload
            out_valid <= 1'b1;
            out_last  <= (send_len == 2'd0);
            idx       <= 2'd0;
        end else if (more) begin
            out_last <= (idx + 2'd1 == len_q);
            idx      <= idx + 2'd1;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_byte <= send_id;
            len_q    <= send_len;
            b0_q     <= send_b0;
            b1_q     <= send_b1;
        end else if (more) begin
            out_byte <= (idx == 2'd0) ? b0_q : b1_q;
        end
    end

    // Drops on the final byte so the sequencer can release busy next cycle
    assign serial_busy = more;

endmodule

// ==== hdl/cfg_controller.sv ====
`timescale 1ns/1ps
`include "cfg_consts.svh"

module cfg_controller (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  cfg_pkg::byte_t        in_byte,
    input  logic [`NUM_PORTS-1:0] direction,
    input  logic [`NUM_PORTS-1:0] num_channels,
    output logic                  busy,
    output logic                  out_valid,
    output cfg_pkg::byte_t        out_byte,
    output logic                  out_last
);
    import cfg_pkg::*;

    // Assembled command fields
    logic      cmd_done;
    cmd_id_t   cmd_id;
    port_t     port;
    reg_addr_t reg_addr;
    byte_t     value;

    // Search control between sequencer and slot counter
    logic      start;
    logic      step;
    logic      bank_end;

    // Reply handoff
    logic       send;
    cmd_id_t    send_id;
    logic [1:0] send_len;
    byte_t      send_b0;
    byte_t      send_b1;
    logic       serial_busy;

    table_if tbl ();

    cmd_assembler u_assembler (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_byte(in_byte), .busy(busy),
        .cmd_done(cmd_done), .cmd_id(cmd_id), .port(port), .reg_addr(reg_addr),
        .value(value)
    );

    cmd_sequencer u_sequencer (
        .clk(clk), .reset(reset), .cmd_done(cmd_done), .cmd_id(cmd_id), .port(port),
        .reg_addr(reg_addr), .value(value), .direction(direction),
        .num_channels(num_channels), .serial_busy(serial_busy), .busy(busy),
        .start(start), .step(step), .bank_end(bank_end), .tbl(tbl.seq), .send(send),
        .send_id(send_id), .send_len(send_len), .send_b0(send_b0), .send_b1(send_b1)
    );

    slot_counter u_counter (
        .clk(clk), .reset(reset), .start(start), .step(step), .tbl(tbl.counter),
        .bank_end(bank_end)
    );

    config_table u_table (.clk(clk), .reset(reset), .tbl(tbl.storage));

    reply_serializer u_serializer (
        .clk(clk), .reset(reset), .send(send), .send_id(send_id), .send_len(send_len),
        .send_b0(send_b0), .send_b1(send_b1), .out_valid(out_valid),
        .out_byte(out_byte), .out_last(out_last), .serial_busy(serial_busy)
    );

endmodule

// ==== verification/cfg_controller_chk.sv ====
`timescale 1ns/1ps

module cfg_controller_chk (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic out_valid,
    input logic out_last
);
    // Failed assertions so far, watched from the testbench
    int unsigned error_count = 0;

    // Reply bytes only while a command is in progress
    valid_in_busy: assert property (@(posedge clk) disable iff (reset) out_valid |-> busy)
        else begin
            error_count++;
            $error("out_valid high while busy is low");
        end

    // Last marker belongs to a valid byte
    last_with_valid: assert property (@(posedge clk) disable iff (reset) out_last |-> out_valid)
        else begin
            error_count++;
            $error("out_last high without out_valid");
        end

    // Controller comes out of reset idle and quiet
    idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !busy && !out_valid)
        else begin
            error_count++;
            $error("busy or out_valid high right after reset");
        end

    // Reply ends cleanly, no stray byte behind the last one
    quiet_after_last: assert property (@(posedge clk) disable iff (reset) out_last |=> !out_valid)
        else begin
            error_count++;
            $error("out_valid high on the cycle after out_last");
        end

endmodule

bind cfg_controller cfg_controller_chk u_chk (
    .clk(clk), .reset(reset), .busy(busy), .out_valid(out_valid), .out_last(out_last)
);

// ==== verification/tb_cfg_controller.sv ====
`timescale 1ns/1ps
`include "cfg_consts.svh"

module tb_cfg_controller;
    import cfg_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    byte_t                 in_byte;
    logic [`NUM_PORTS-1:0] direction;
    logic [`NUM_PORTS-1:0] num_channels;
    logic                  busy;
    logic                  out_valid;
    byte_t                 out_byte;
    logic                  out_last;
    integer                seed;

    // Reference table, indexed by bank and slot
    logic      ref_used [16][`NUM_SLOTS];
    reg_addr_t ref_addr [16][`NUM_SLOTS];
    byte_t     ref_val  [16][`NUM_SLOTS];

    // Reply seen on the output and the reply the reference predicts
    byte_t got_bytes[$];
    logic  got_last[$];
    byte_t exp_bytes[$];

    cfg_controller UUT (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_byte(in_byte),
        .direction(direction), .num_channels(num_channels), .busy(busy),
        .out_valid(out_valid), .out_byte(out_byte), .out_last(out_last)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Bank is {port, direction bit, channel bit} of that port
    function automatic bank_t bank_of(port_t port);
        return {port, direction[port], num_channels[port]};
    endfunction

    // Slots fill in order, so the first unused slot ends the search
    function automatic int find_slot(bank_t bank, reg_addr_t addr);
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            if (!ref_used[bank][s] || ref_addr[bank][s] == addr) begin
                return s;
            end
        end
        return -1;
    endfunction

    task automatic wait_not_busy(input string name);
        int n;
        n = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("%s: timed out waiting for busy to fall", name);
                stop_with_failure();
            end
        end
    endtask

    // Sends the command bytes, then collects the reply until busy falls
    task automatic run_command(input string name, input byte_t cmd[$]);
        int n;
        wait_not_busy(name);
        got_bytes.delete();
        got_last.delete();
        foreach (cmd[i]) begin
            in_valid = 1'b1;
            in_byte  = cmd[i];
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        assert (busy) else begin
            $display("%s: busy did not rise after the last command byte", name);
            stop_with_failure();
        end
        n = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            if (out_valid) begin
                got_bytes.push_back(out_byte);
                got_last.push_back(out_last);
            end
            n++;
            if (n > TIMEOUT_CYCLES) begin
                $display("%s: timed out waiting for the command to finish", name);
                stop_with_failure();
            end
        end
        assert (got_bytes.size() == exp_bytes.size()) else begin
            $display("[FAIL] %s: reply length expected %0d actual %0d", name,
                     exp_bytes.size(), got_bytes.size());
            stop_with_failure();
        end
        foreach (exp_bytes[i]) begin
            assert (got_bytes[i] == exp_bytes[i]) else begin
                $display("[FAIL] %s: byte %0d expected 0x%02h actual 0x%02h", name, i,
                         exp_bytes[i], got_bytes[i]);
                stop_with_failure();
            end
            assert (got_last[i] == (i == exp_bytes.size() - 1)) else begin
                $display("[FAIL] %s: out_last of byte %0d expected %0b actual %0b", name, i,
                         (i == exp_bytes.size() - 1), got_last[i]);
                stop_with_failure();
            end
        end
    endtask

    task automatic do_get(input string name, input port_t port, input reg_addr_t addr);
        bank_t bank;
        int    s;
        bank = bank_of(port);
        s = find_slot(bank, addr);
        exp_bytes.delete();
        if (s >= 0 && ref_used[bank][s]) begin
            exp_bytes = '{`CMD_DATA_REG, byte_t'(addr), ref_val[bank][s]};
        end else begin
            exp_bytes = '{`CMD_NOT_FOUND};
        end
        run_command(name, '{`CMD_GET_REG, byte_t'(port), byte_t'(addr)});
    endtask

    task automatic do_set(input string name, input port_t port, input reg_addr_t addr,
                          input byte_t value);
        bank_t bank;
        int    s;
        bank = bank_of(port);
        s = find_slot(bank, addr);
        exp_bytes.delete();
        // Match or free slot takes the entry, a full bank answers not found
        if (s >= 0) begin
            ref_used[bank][s] = 1'b1;
            ref_addr[bank][s] = addr;
            ref_val[bank][s]  = value;
        end else begin
            exp_bytes = '{`CMD_NOT_FOUND};
        end
        run_command(name, '{`CMD_SET_REG, byte_t'(port), byte_t'(addr), value});
    endtask

    task automatic check_bank_count(input string name, input bank_t bank);
        int exp_n;
        int got_n;
        exp_n = 0;
        got_n = 0;
        for (int s = 0; s < `NUM_SLOTS; s++) begin
            exp_n += ref_used[bank][s];
            got_n += UUT.u_table.used_q[{bank, slot_t'(s)}];
        end
        assert (got_n == exp_n) else begin
            $display("[FAIL] %s: used slots expected %0d actual %0d", name, exp_n, got_n);
            stop_with_failure();
        end
    endtask

    // Bound checker failures end the run at the next edge
    always @(posedge clk) begin
        if (UUT.u_chk.error_count != 0) begin
            $display("A bound protocol assertion failed");
            stop_with_failure();
        end
    end

    initial begin
        seed         = 32'h2a559105;
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_byte      = '0;
        direction    = '0;
        num_channels = '0;
        for (int b = 0; b < 16; b++) begin
            for (int s = 0; s < `NUM_SLOTS; s++) begin
                ref_used[b][s] = 1'b0;
            end
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;

        do_get("get_empty", 2'd0, 6'h05);
        do_set("set_first", 2'd0, 6'h05, byte_t'($random(seed)));
        do_get("get_after_set", 2'd0, 6'h05);

        // Same address again replaces the value in place
        do_set("set_replace", 2'd0, 6'h05, byte_t'($random(seed)));
        do_get("get_replaced", 2'd0, 6'h05);
        check_bank_count("bank_one_entry", bank_of(2'd0));

        // Same address in other banks
        for (int p = 1; p < `NUM_PORTS; p++) begin
            do_set("set_other_port", port_t'(p), 6'h05, byte_t'($random(seed)));
        end
        direction = 4'b0010;
        do_set("set_direction", 2'd1, 6'h05, byte_t'($random(seed)));
        num_channels = 4'b0010;
        do_set("set_channel", 2'd1, 6'h05, byte_t'($random(seed)));
        do_get("get_channel", 2'd1, 6'h05);
        num_channels = 4'b0000;
        do_get("get_direction", 2'd1, 6'h05);
        direction = 4'b0000;
        for (int p = 0; p < `NUM_PORTS; p++) begin
            do_get("get_other_port", port_t'(p), 6'h05);
        end

        // Fill the bank of port 3 with direction and channel set
        direction    = 4'b1000;
        num_channels = 4'b1000;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            do_set($sformatf("fill_%0d", i), 2'd3, reg_addr_t'(6'h10 + i),
                   byte_t'($random(seed)));
        end
        do_set("set_bank_full", 2'd3, 6'h30, byte_t'($random(seed)));
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            do_get($sformatf("readback_%0d", i), 2'd3, reg_addr_t'(6'h10 + i));
        end
        do_get("get_bank_full", 2'd3, 6'h30);

        // Unknown id is a one-byte command with no reply
        exp_bytes.delete();
        run_command("unknown_id", '{8'h55});
        do_get("get_after_unknown", 2'd0, 6'h05);
        wait_not_busy("end_of_run");

        if (UUT.u_chk.error_count != 0) begin
            stop_with_failure();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/cfg_pkg.sv
hdl/table_if.sv
hdl/cmd_assembler.sv
hdl/slot_counter.sv
hdl/config_table.sv
hdl/cmd_sequencer.sv
hdl/reply_serializer.sv
hdl/cfg_controller.sv
verification/cfg_controller_chk.sv
verification/tb_cfg_controller.sv
